// File: verilog/video_pkg.sv
// shared types and pipeline constants for the ZBT frame display
// every RTL module that needs a width or a latency imports this package
`default_nettype none

package video_pkg;

   ////////////////////
   // pixel and memory word types

   // one RGB pixel with 6 bits per channel
   // red in [17:12], green in [11:6], blue in [5:0]
   typedef logic [17:0] pixel_t;

   // one ZBT word holds two pixels
   // even column in [35:18], odd column in [17:0]
   typedef logic [35:0] vram_word_t;

   // frame buffer address
   // line number in [18:9], column / 2 in [8:0]
   typedef logic [18:0] vram_addr_t;

   ////////////////////
   // raster counter types

   // pixel position on the current line, wide enough for XGA totals
   typedef logic [10:0] hcount_t;

   // line number within the frame
   typedef logic [9:0]  vcount_t;

   ////////////////////
   // pipeline constants

   // ZBT read latency
   // data for an address driven in cycle k is on the read bus in cycle k+2
   localparam int READ_LATENCY = 2;

   // how far ahead of the raster the display read address runs
   // covers the port register, the memory, the input stages and both latches
   localparam int FORECAST = 8;

endpackage

`default_nettype wire

// File: verilog/vram_if.sv
// frame buffer port between the memory arbiter and the pixel unpacker
// the top ties the address side to the ZBT pins and feeds read data back in
`timescale 1ns/1ps
`default_nettype none

interface vram_if
   import video_pkg::*;
();

   // registered memory address, read or write
   vram_addr_t addr;
   // write strobe, memory captures addr and wdata on every clock it is high
   logic       we;
   // pattern data to store
   vram_word_t wdata;
   // word returned READ_LATENCY clocks after its address
   vram_word_t rdata;

   // arbiter side
   modport mem_master (
      output addr,
      output we,
      output wdata
   );

   // pin side at the top level
   modport mem_port (
      input  addr,
      input  we,
      input  wdata,
      output rdata
   );

   // pixel unpacker only looks at the returning words
   modport reader (
      input  rdata
   );

endinterface

`default_nettype wire

// File: verilog/raster_timing.sv
// raster generator for a parameterized VGA style display
// produces pixel and line counters with sync and blank aligned to them
// defaults give XGA 1024x768 with 1344 clocks per line and 806 lines
`timescale 1ns/1ps
`default_nettype none

module raster_timing
   import video_pkg::*;
#(
   parameter int H_ACTIVE     = 1024,
   parameter int H_SYNC_START = 1048,
   parameter int H_SYNC_END   = 1184,
   parameter int H_TOTAL      = 1344,
   parameter int V_ACTIVE     = 768,
   parameter int V_SYNC_START = 777,
   parameter int V_SYNC_END   = 783,
   parameter int V_TOTAL      = 806
)
(
   input  logic    clk,
   input  logic    rst_n,
   output hcount_t hcount,
   output vcount_t vcount,
   output logic    hsync,
   output logic    vsync,
   output logic    blank
);

   hcount_t h_next;
   vcount_t v_next;
   logic    h_wrap;

   ////////////////////
   // next raster position

   always_comb
   begin
      h_wrap = (hcount == hcount_t'(H_TOTAL - 1));
      h_next = h_wrap ? '0 : hcount + 1'b1;
      v_next = vcount;
      // line advances only on the last pixel of a line
      if (h_wrap)
      begin
         v_next = (vcount == vcount_t'(V_TOTAL - 1)) ? '0 : vcount + 1'b1;
      end
   end

   ////////////////////
   // counters, sync and blank

   // sync and blank are decoded from the next position
   // so they line up with the counter value on the same clock
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         hcount <= '0;
         vcount <= '0;
         // both syncs are active low
         hsync  <= 1'b1;
         vsync  <= 1'b1;
         // first pixel after reset stays blanked
         blank  <= 1'b1;
      end
      else
      begin
         hcount <= h_next;
         vcount <= v_next;
         hsync  <= !((h_next >= hcount_t'(H_SYNC_START)) &&
                     (h_next <  hcount_t'(H_SYNC_END)));
         vsync  <= !((v_next >= vcount_t'(V_SYNC_START)) &&
                     (v_next <  vcount_t'(V_SYNC_END)));
         // blank from end of active area until the counter wraps
         blank  <= (h_next >= hcount_t'(H_ACTIVE)) ||
                   (v_next >= vcount_t'(V_ACTIVE));
      end
   end

   ////////////////////
   // checks

   // counters never leave the raster
   a_hcount_range : assert property (@(posedge clk) disable iff (!rst_n)
      hcount < hcount_t'(H_TOTAL));

   a_vcount_range : assert property (@(posedge clk) disable iff (!rst_n)
      vcount < vcount_t'(V_TOTAL));

endmodule

`default_nettype wire

// File: verilog/vram_arbiter.sv
// owns the single ZBT port of the display
// issues display reads FORECAST pixels ahead of the raster and, during
// blanking, replaces them with writes of a bar pattern from a free counter
`timescale 1ns/1ps
`default_nettype none

module vram_arbiter
   import video_pkg::*;
#(
   parameter int H_TOTAL = 1344,
   parameter int V_TOTAL = 806
)
(
   input  logic          clk,
   input  logic          rst_n,
   input  hcount_t       hcount,
   input  vcount_t       vcount,
   input  logic          blank,
   input  logic          pattern_write,
   input  logic          pattern_slow,
   vram_if.mem_master    mem
);

   logic [11:0] h_ahead;
   logic        h_wrap;
   hcount_t     fh;
   vcount_t     fv;
   vram_addr_t  read_addr;

   vram_addr_t  pat_count;
   logic [3:0]  pat_nib;
   vram_word_t  pat_word;
   logic        write_now;

   ////////////////////
   // read address forecast

   // position FORECAST clocks from now, wrapping into the next line and frame
   always_comb
   begin
      h_ahead = {1'b0, hcount} + 12'(FORECAST);
      h_wrap  = (h_ahead >= 12'(H_TOTAL));
      fh      = h_wrap ? hcount_t'(h_ahead - 12'(H_TOTAL)) : hcount_t'(h_ahead);
      fv      = vcount;
      if (h_wrap)
      begin
         fv = (vcount == vcount_t'(V_TOTAL - 1)) ? '0 : vcount + 1'b1;
      end
   end

   // two pixels per word so the column drops its lowest bit
   assign read_addr = {fv, fh[9:1]};

   ////////////////////
   // test pattern source

   // free running, also serves as the write address
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         pat_count <= '0;
      end
      else
      begin
         pat_count <= pat_count + 1'b1;
      end
   end

   // slow pattern uses one counter bit higher, so bars are twice as wide
   assign pat_nib  = pattern_slow ? pat_count[7:4] : pat_count[6:3];
   // four bytes with the nibble on top, spare 4 bits of the word zero
   assign pat_word = {4'b0000, {4{pat_nib, 4'b0000}}};

   // pattern writes take the port only while the raster is blanked
   assign write_now = blank && pattern_write;

   ////////////////////
   // memory port registers

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         mem.we <= 1'b0;
      end
      else
      begin
         mem.we <= write_now;
      end
   end

   // a write steals the slot of the display read
   always_ff @(posedge clk)
   begin
      mem.addr  <= write_now ? pat_count : read_addr;
      mem.wdata <= pat_word;
   end

   // port lags blank by one register
   // so a write may only spill onto the first pixel of an active line
   a_we_in_blank : assert property (@(posedge clk) disable iff (!rst_n)
      mem.we |-> (blank || (hcount == '0)));

endmodule

`default_nettype wire

// File: verilog/pixel_unpack.sv
// turns returning ZBT words into one pixel per clock
// words pass a short alignment pipe, are double latched on pixel pairs,
// split by column parity, optionally replaced by test bars and registered
`timescale 1ns/1ps
`default_nettype none

module pixel_unpack
   import video_pkg::*;
#(
   parameter int BAR_LSB = 6
)
(
   input  logic    clk,
   input  logic    rst_n,
   input  hcount_t hcount,
   input  logic    hsync,
   input  logic    vsync,
   input  logic    blank,
   input  logic    test_bars,
   vram_if.reader  mem,
   output pixel_t  rgb,
   output logic    hsync_out,
   output logic    vsync_out,
   output logic    blank_b
);

   // address forecast at hcount h must meet the display latch at h + FORECAST
   // one port register, the memory, these stages and the two latches
   localparam int RD_STAGES = FORECAST - READ_LATENCY - 3;

   vram_word_t rd_pipe [RD_STAGES];
   vram_word_t rd_latch;
   vram_word_t disp_latch;
   pixel_t     vr_pixel;
   pixel_t     bar_pixel;

   ////////////////////
   // word alignment

   always_ff @(posedge clk)
   begin
      rd_pipe[0] <= mem.rdata;
      for (int i = 1; i < RD_STAGES; i++)
      begin
         rd_pipe[i] <= rd_pipe[i-1];
      end
   end

   // capture on even pixels, hand over on the odd one
   // display latch then holds the word for the next even/odd pair
   always_ff @(posedge clk)
   begin
      if (!hcount[0])
      begin
         rd_latch <= rd_pipe[RD_STAGES-1];
      end
      else
      begin
         disp_latch <= rd_latch;
      end
   end

   ////////////////////
   // pixel select

   // even column sits in the upper half
   assign vr_pixel = hcount[0] ? disp_latch[17:0] : disp_latch[35:18];

   // hardwired vertical bars, bar index lands in pixel bits [7:5]
   assign bar_pixel = {10'b0, hcount[BAR_LSB +: 3], 5'b0};

   ////////////////////
   // output registers

   always_ff @(posedge clk)
   begin
      rgb <= test_bars ? bar_pixel : vr_pixel;
   end

   // controls delayed one clock to sit with the registered pixel
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         hsync_out <= 1'b1;
         vsync_out <= 1'b1;
         blank_b   <= 1'b0;
      end
      else
      begin
         hsync_out <= hsync;
         vsync_out <= vsync;
         blank_b   <= !blank;
      end
   end

endmodule

`default_nettype wire

// File: verilog/zbt_frame_display.sv
// top level of the ZBT frame buffer display
// raster timing drives both the memory arbiter and the pixel unpacker,
// memory pins and VGA outputs are plain ports
`timescale 1ns/1ps
`default_nettype none

module zbt_frame_display
   import video_pkg::*;
#(
   parameter int H_ACTIVE     = 1024,
   parameter int H_SYNC_START = 1048,
   parameter int H_SYNC_END   = 1184,
   parameter int H_TOTAL      = 1344,
   parameter int V_ACTIVE     = 768,
   parameter int V_SYNC_START = 777,
   parameter int V_SYNC_END   = 783,
   parameter int V_TOTAL      = 806,
   parameter int BAR_LSB      = 6
)
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        pattern_write,
   input  logic        pattern_slow,
   input  logic        test_bars,
   input  logic [35:0] ram_rdata,
   output logic [18:0] ram_addr,
   output logic        ram_we,
   output logic [35:0] ram_wdata,
   output logic [7:0]  vga_red,
   output logic [7:0]  vga_green,
   output logic [7:0]  vga_blue,
   output logic        vga_hsync,
   output logic        vga_vsync,
   output logic        vga_blank_b
);

   hcount_t hcount;
   vcount_t vcount;
   logic    hsync;
   logic    vsync;
   logic    blank;
   pixel_t  rgb;

   vram_if vram_i ();

   ////////////////////
   // decode, raster timing

   raster_timing #(
      .H_ACTIVE     (H_ACTIVE),
      .H_SYNC_START (H_SYNC_START),
      .H_SYNC_END   (H_SYNC_END),
      .H_TOTAL      (H_TOTAL),
      .V_ACTIVE     (V_ACTIVE),
      .V_SYNC_START (V_SYNC_START),
      .V_SYNC_END   (V_SYNC_END),
      .V_TOTAL      (V_TOTAL)
   ) raster_timing_i (
      .clk    (clk),
      .rst_n  (rst_n),
      .hcount (hcount),
      .vcount (vcount),
      .hsync  (hsync),
      .vsync  (vsync),
      .blank  (blank)
   );

   ////////////////////
   // execute, frame buffer access

   vram_arbiter #(
      .H_TOTAL (H_TOTAL),
      .V_TOTAL (V_TOTAL)
   ) vram_arbiter_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .hcount        (hcount),
      .vcount        (vcount),
      .blank         (blank),
      .pattern_write (pattern_write),
      .pattern_slow  (pattern_slow),
      .mem           (vram_i.mem_master)
   );

   // memory pins, same direction as the mem_port view
   assign ram_addr     = vram_i.addr;
   assign ram_we       = vram_i.we;
   assign ram_wdata    = vram_i.wdata;
   assign vram_i.rdata = ram_rdata;

   ////////////////////
   // result, pixel output

   pixel_unpack #(
      .BAR_LSB (BAR_LSB)
   ) pixel_unpack_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .hcount    (hcount),
      .hsync     (hsync),
      .vsync     (vsync),
      .blank     (blank),
      .test_bars (test_bars),
      .mem       (vram_i.reader),
      .rgb       (rgb),
      .hsync_out (vga_hsync),
      .vsync_out (vga_vsync),
      .blank_b   (vga_blank_b)
   );

   // 6 bit channels on the top of the 8 bit DAC inputs
   assign vga_red   = {rgb[17:12], 2'b00};
   assign vga_green = {rgb[11:6], 2'b00};
   assign vga_blue  = {rgb[5:0], 2'b00};

endmodule

`default_nettype wire

// File: tb/zbt_model.sv
// behavioral ZBT SRAM for the testbench
// read data follows its address by two clocks and writes land on the clock edge
// preload fills words by backdoor, a small log keeps every write seen
`timescale 1ns/1ps
`default_nettype none

module zbt_model
(
   input  logic        clk,
   input  logic [18:0] addr,
   input  logic        we,
   input  logic [35:0] wdata,
   output logic [35:0] rdata
);

   localparam int LOG_DEPTH = 1024;

   logic [35:0] mem [1 << 19];
   logic [35:0] rd_stage;
   // write log in arrival order
   logic [18:0] wr_addr [LOG_DEPTH];
   logic [35:0] wr_data [LOG_DEPTH];
   int          wr_count = 0;

   // read stage first, so a write on the same clock is not seen
   always @(posedge clk)
   begin
      rd_stage <= mem[addr];
      rdata    <= rd_stage;
      if (we)
      begin
         mem[addr] = wdata;
         if (wr_count < LOG_DEPTH)
         begin
            wr_addr[10'(wr_count)] = addr;
            wr_data[10'(wr_count)] = wdata;
         end
         wr_count = wr_count + 1;
      end
   end

   task automatic preload(input logic [18:0] a, input logic [35:0] d);
      mem[a] = d;
   endtask

   task automatic clear_log();
      wr_count = 0;
   endtask

endmodule

`default_nettype wire

// File: tb/tb_zbt_frame_display.sv
// directed testbench for the ZBT frame display on a small raster
// the raster is followed at the VGA pins, all checks work from sync and
// blank edges, the memory model contents and the rules for bars and patterns
`timescale 1ns/1ps
`default_nettype none

module tb_zbt_frame_display;

   localparam int H_ACTIVE = 16;
   localparam int H_TOTAL  = 28;
   localparam int V_ACTIVE = 6;
   localparam int V_TOTAL  = 10;
   localparam int BAR_LSB  = 2;
   localparam int FRAME    = H_TOTAL * V_TOTAL;
   localparam int unsigned SEED = 32'h85fd78c2;

   logic        clk;
   logic        rst_n;
   logic        pattern_write;
   logic        pattern_slow;
   logic        test_bars;
   logic [35:0] ram_rdata;
   logic [18:0] ram_addr;
   logic        ram_we;
   logic [35:0] ram_wdata;
   logic [7:0]  vga_red;
   logic [7:0]  vga_green;
   logic [7:0]  vga_blue;
   logic        vga_hsync;
   logic        vga_vsync;
   logic        vga_blank_b;

   // raster position seen at the outputs, one update per clock
   logic prev_hs = 1'b1;
   logic prev_vs = 1'b1;
   logic prev_bl = 1'b0;
   logic hs_fall;
   logic vs_fall;
   logic bl_fall;
   int   col = 0;
   int   line = 0;

   zbt_frame_display #(
      .H_ACTIVE (H_ACTIVE), .H_SYNC_START (18), .H_SYNC_END (20), .H_TOTAL (H_TOTAL),
      .V_ACTIVE (V_ACTIVE), .V_SYNC_START (7), .V_SYNC_END (8), .V_TOTAL (V_TOTAL),
      .BAR_LSB  (BAR_LSB)
   ) zbt_frame_display_i (.*);

   zbt_model zbt_model_i (
      .clk (clk), .addr (ram_addr), .we (ram_we), .wdata (ram_wdata), .rdata (ram_rdata)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   ////////////////////
   // helpers

   task automatic check_equal(input logic [35:0] actual, input logic [35:0] expected,
                              input string what);
      if (actual !== expected)
      begin
         $display("[FAIL] %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
         $display("Something failed");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic timed_out(input string what);
      $display("timed out waiting for %s", what);
      $display("Something failed");
      $fatal(1, "timeout");
   endtask

   // inputs change just after the rising edge
   task automatic set_controls(input logic wr, input logic slow, input logic bars);
      @(posedge clk);
      #1;
      pattern_write = wr;
      pattern_slow  = slow;
      test_bars     = bars;
   endtask

   // outputs are read at the falling edge, line restarts at -1 on vsync fall
   task automatic sample();
      @(negedge clk);
      hs_fall = prev_hs && !vga_hsync;
      vs_fall = prev_vs && !vga_vsync;
      bl_fall = prev_bl && !vga_blank_b;
      if (vs_fall)
      begin
         line = -1;
      end
      if (!prev_bl && vga_blank_b)
      begin
         line = line + 1;
         col  = 0;
      end
      else if (vga_blank_b)
      begin
         col = col + 1;
      end
      prev_hs = vga_hsync;
      prev_vs = vga_vsync;
      prev_bl = vga_blank_b;
   endtask

   task automatic wait_vsync_fall();
      int n;
      n = 0;
      do
      begin
         sample();
         n = n + 1;
         if (n > 2 * FRAME)
         begin
            timed_out("a vsync fall");
         end
      end
      while (!vs_fall);
   endtask

   // 6 bit channels sit on top of the 8 bit outputs
   function automatic logic [23:0] to_vga(input logic [17:0] pix);
      return {pix[17:12], 2'b00, pix[11:6], 2'b00, pix[5:0], 2'b00};
   endfunction

   // byte with the pattern nibble on top, repeated four times
   function automatic logic [35:0] pattern_word(input logic [18:0] a, input logic slow);
      logic [3:0] nib;
      nib = slow ? a[7:4] : a[6:3];
      return {4'b0000, nib, 4'b0000, nib, 4'b0000, nib, 4'b0000, nib, 4'b0000};
   endfunction

   ////////////////////
   // directed tests

   task automatic check_idle_outputs();
      check_equal(36'(ram_we), 36'(0), "ram_we in reset");
      check_equal(36'(vga_blank_b), 36'(0), "vga_blank_b in reset");
      check_equal(36'({vga_hsync, vga_vsync}), 36'(3), "syncs in reset");
   endtask

   task automatic check_reset();
      repeat (2)
      begin
         sample();
         check_idle_outputs();
      end
      @(posedge clk);
      #1;
      rst_n         = 1'b1;
      pattern_write = 1'b0;
      // still the reset values until the next edge
      sample();
      check_idle_outputs();
   endtask

   task automatic check_raster_shape();
      int clocks;
      int since_hs;
      int run;
      int lines;
      int hfalls;
      clocks = 0;
      since_hs = 0;
      run = 0;
      lines = 0;
      hfalls = 0;
      wait_vsync_fall();
      do
      begin
         sample();
         clocks = clocks + 1;
         since_hs = since_hs + 1;
         run = run + (vga_blank_b ? 1 : 0);
         if (bl_fall)
         begin
            check_equal(36'(run), 36'(H_ACTIVE), "active clocks per line");
            run = 0;
            lines = lines + 1;
         end
         if (hs_fall)
         begin
            if (hfalls > 0)
            begin
               check_equal(36'(since_hs), 36'(H_TOTAL), "clocks between hsync falls");
            end
            since_hs = 0;
            hfalls = hfalls + 1;
         end
         if (clocks > 2 * FRAME)
         begin
            timed_out("the next vsync fall");
         end
      end
      while (!vs_fall);
      check_equal(36'(lines), 36'(V_ACTIVE), "active lines per frame");
      check_equal(36'(hfalls), 36'(V_TOTAL), "lines between vsync falls");
      check_equal(36'(clocks), 36'(FRAME), "clocks per frame");
   endtask

   // one full frame, memory words or test bars depending on bars
   task automatic check_frame(input logic bars);
      int          n;
      int          pixels;
      logic [18:0] a;
      logic [35:0] word;
      logic [17:0] pix;
      n = 0;
      pixels = 0;
      wait_vsync_fall();
      do
      begin
         sample();
         n = n + 1;
         if (vga_blank_b)
         begin
            if (bars)
            begin
               pix = 18'(((col >> BAR_LSB) % 8) << 5);
            end
            else
            begin
               // two pixels per word, even column in the upper half
               a    = {10'(line), 9'(col / 2)};
               word = zbt_model_i.mem[a];
               pix  = ((col % 2) == 1) ? word[17:0] : word[35:18];
            end
            check_equal(36'({vga_red, vga_green, vga_blue}), 36'(to_vga(pix)),
                        $sformatf("pixel at line %0d column %0d", line, col));
            pixels = pixels + 1;
         end
         if (n > 2 * FRAME)
         begin
            timed_out("the end of a frame");
         end
      end
      while (!vs_fall);
      check_equal(36'(pixels), 36'(H_ACTIVE * V_ACTIVE), "active pixels per frame");
   endtask

   task automatic check_pattern_writes(input logic slow);
      int n;
      int frames;
      int count;
      n = 0;
      frames = 0;
      set_controls(1'b0, slow, 1'b0);
      zbt_model_i.clear_log();
      set_controls(1'b1, slow, 1'b0);
      do
      begin
         sample();
         n = n + 1;
         // port write and blanked output share the same clock
         if (ram_we)
         begin
            check_equal(36'(vga_blank_b), 36'(0), "vga_blank_b during a pattern write");
         end
         frames = frames + (vs_fall ? 1 : 0);
         if (n > 3 * FRAME)
         begin
            timed_out("two frames of pattern writes");
         end
      end
      while (frames < 2);
      set_controls(1'b0, slow, 1'b0);
      // last registered write reaches the model one edge later
      sample();
      sample();
      count = (zbt_model_i.wr_count < 1024) ? zbt_model_i.wr_count : 1024;
      check_equal(36'(count > 0), 36'(1), "pattern writes recorded");
      for (int i = 0; i < count; i++)
      begin
         check_equal(zbt_model_i.wr_data[10'(i)],
                     pattern_word(zbt_model_i.wr_addr[10'(i)], slow),
                     $sformatf("pattern word at %h", zbt_model_i.wr_addr[10'(i)]));
      end
   endtask

   ////////////////////
   // sequence

   initial
   begin
      int unsigned seed;
      logic [63:0] r;
      rst_n         = 1'b0;
      // a write request during reset must not reach the port
      pattern_write = 1'b1;
      pattern_slow  = 1'b0;
      test_bars     = 1'b0;
      seed = $urandom(SEED);
      // every word the raster can forecast, lines and half columns
      for (int v = 0; v < V_TOTAL; v++)
      begin
         for (int c = 0; c < H_TOTAL / 2; c++)
         begin
            r = {$urandom(), $urandom()};
            zbt_model_i.preload({10'(v), 9'(c)}, r[35:0]);
         end
      end
      check_reset();
      check_raster_shape();
      check_frame(1'b0);
      check_pattern_writes(1'b0);
      check_pattern_writes(1'b1);
      set_controls(1'b0, 1'b0, 1'b1);
      check_frame(1'b1);
      $display("Everything OK");
      $finish;
   end

endmodule

`default_nettype wire

// File: tb.f
verilog/video_pkg.sv
verilog/vram_if.sv
verilog/raster_timing.sv
verilog/vram_arbiter.sv
verilog/pixel_unpack.sv
verilog/zbt_frame_display.sv
tb/zbt_model.sv
tb/tb_zbt_frame_display.sv

// File: Makefile
# Verilator build and run of the ZBT frame display testbench

SIM = obj_dir/Vtb_zbt_frame_display

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module tb_zbt_frame_display -f tb.f

run: compile
	./$(SIM)

clean:
	rm -rf obj_dir
